//--- Bender.yml
package:
  name: uart_subsystem

sources:
  - files:
      - hw/uart_soc_pkg.sv
      - hw/uart_tx.sv
      - hw/uart_rx.sv
      - hw/uart_regs.sv
      - hw/bus_arbiter.sv
      - hw/uart_subsystem.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_uart_subsystem.sv

//--- hw/bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   req_a_i,
    input  wire logic                   req_b_i,
    input  wire uart_soc_pkg::bus_req_t cmd_a_i,
    input  wire uart_soc_pkg::bus_req_t cmd_b_i,
    output logic                        ack_a_o,
    output logic                        ack_b_o,
    output uart_soc_pkg::data_t         rdata_a_o,
    output uart_soc_pkg::data_t         rdata_b_o,
    output logic                        bus_valid_o,
    output uart_soc_pkg::bus_req_t      bus_cmd_o,
    input  wire uart_soc_pkg::data_t    bus_rdata_i
);

    import uart_soc_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        HOLD
    } arb_state_e;

    arb_state_e state_q;
    // Port B served last, also the current grant
    logic       last_b_q;
    logic       pick_b;
    logic       granted_req;
    logic       ack_a_q;
    logic       ack_b_q;
    data_t      rdata_a_q;
    data_t      rdata_b_q;

    // Tie goes to the port not served last
    assign pick_b      = req_b_i && (!req_a_i || !last_b_q);
    assign granted_req = last_b_q ? req_b_i : req_a_i;

    // ====================
    // Grant and handshake
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q  <= IDLE;
            last_b_q <= 1'b0;
            ack_a_q  <= 1'b0;
            ack_b_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_a_i || req_b_i) begin
                        last_b_q <= pick_b;
                        state_q  <= ACCESS;
                    end
                end
                ACCESS: begin
                    ack_a_q <= !last_b_q;
                    ack_b_q <= last_b_q;
                    state_q <= HOLD;
                end
                HOLD: begin
                    // Four-phase return to zero
                    if (!granted_req) begin
                        ack_a_q <= 1'b0;
                        ack_b_q <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ACCESS) begin
            if (last_b_q) begin
                rdata_b_q <= bus_rdata_i;
            end else begin
                rdata_a_q <= bus_rdata_i;
            end
        end
    end

    assign bus_valid_o = (state_q == ACCESS);
    assign bus_cmd_o   = last_b_q ? cmd_b_i : cmd_a_i;
    assign ack_a_o     = ack_a_q;
    assign ack_b_o     = ack_b_q;
    assign rdata_a_o   = rdata_a_q;
    assign rdata_b_o   = rdata_b_q;

    a_ack_exclusive : assert property (
        @(posedge clk) disable iff (reset) !(ack_a_o && ack_b_o)
    ) else $error("both host acks high");

    a_single_strobe : assert property (
        @(posedge clk) disable iff (reset) bus_valid_o |=> !bus_valid_o
    ) else $error("bus strobe longer than one cycle");

endmodule

`default_nettype wire

//--- hw/uart_regs.sv
`timescale 1ns/1ns
`default_nettype none

module uart_regs (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    bus_valid_i,
    input  wire uart_soc_pkg::bus_req_t  bus_cmd_i,
    output uart_soc_pkg::data_t          bus_rdata_o,
    output uart_soc_pkg::data_t          tx_data_o,
    output logic                         tx_start_o,
    input  wire logic                    tx_busy_i,
    input  wire uart_soc_pkg::data_t     rx_data_i,
    input  wire logic                    rx_ready_i,
    input  wire uart_soc_pkg::rx_flags_t rx_flags_i,
    output logic                         rx_ack_o,
    output logic                         clr_frame_o,
    output logic                         clr_overrun_o
);

    import uart_soc_pkg::*;

    data_t control_q;
    data_t status;
    data_t tx_data_q;
    logic  tx_start_q;
    logic  wr_ctrl;
    logic  wr_data;
    logic  rd_data;

    // ====================
    // Access decode
    // ====================
    assign wr_ctrl = bus_valid_i && bus_cmd_i.write && (bus_cmd_i.offset == UART_REG_CONTROL);
    assign wr_data = bus_valid_i && bus_cmd_i.write && (bus_cmd_i.offset == UART_REG_DATA);
    assign rd_data = bus_valid_i && !bus_cmd_i.write && (bus_cmd_i.offset == UART_REG_DATA);

    always_comb begin
        status                     = '0;
        status[STAT_TX_EMPTY_BIT]  = !tx_busy_i;
        status[STAT_RX_READY_BIT]  = rx_ready_i;
        status[STAT_FRAME_ERR_BIT] = rx_flags_i.frame_err;
        status[STAT_OVERRUN_BIT]   = rx_flags_i.overrun;
    end

    // Read data valid in the strobe cycle
    always_comb begin
        case (bus_cmd_i.offset)
            UART_REG_CONTROL: bus_rdata_o = control_q;
            UART_REG_STATUS:  bus_rdata_o = status;
            UART_REG_DATA:    bus_rdata_o = rx_data_i;
            default:          bus_rdata_o = '0;
        endcase
    end

    // Reading DATA frees the receive buffer
    assign rx_ack_o = rd_data;

    // ====================
    // Control register
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            control_q <= '0;
        end else if (wr_ctrl) begin
            control_q <= bus_cmd_i.wdata;
        end else begin
            // Clear bits live for one cycle only
            control_q[CTRL_CLR_FRAME_BIT]   <= 1'b0;
            control_q[CTRL_CLR_OVERRUN_BIT] <= 1'b0;
        end
    end

    assign clr_frame_o   = control_q[CTRL_CLR_FRAME_BIT];
    assign clr_overrun_o = control_q[CTRL_CLR_OVERRUN_BIT];

    // ====================
    // Transmit launch
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_start_q <= 1'b0;
        end else begin
            // Write while busy is dropped
            tx_start_q <= wr_data && !tx_busy_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_data && !tx_busy_i) begin
            tx_data_q <= bus_cmd_i.wdata;
        end
    end

    assign tx_data_o  = tx_data_q;
    assign tx_start_o = tx_start_q;

    // Start pulse must never reach a transmitter that is mid-frame
    a_no_start_when_busy : assert property (
        @(posedge clk) disable iff (reset) tx_start_o |-> !tx_busy_i
    ) else $error("tx_start asserted while transmitter busy");

endmodule

`default_nettype wire

//--- hw/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                serial_rx_i,
    input  wire logic                rx_ack_i,
    input  wire logic                clr_frame_i,
    input  wire logic                clr_overrun_i,
    output uart_soc_pkg::data_t      rx_data_o,
    output logic                     rx_ready_o,
    output uart_soc_pkg::rx_flags_t  rx_flags_o
);

    import uart_soc_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_e;

    rx_state_e  state_q;
    baud_cnt_t  cnt_q;
    bit_idx_t   idx_q;
    data_t      shift_q;
    data_t      data_q;
    logic [1:0] sync_q;
    logic       rx_bit;
    logic       bit_end;
    logic       frame_done;
    logic       accept;
    logic       ready_q;
    logic       frame_err_q;
    logic       overrun_q;

    // Two-flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], serial_rx_i};
        end
    end

    assign rx_bit  = sync_q[1];
    assign bit_end = (cnt_q == BIT_LAST);

    // Stop bit sampled at its middle
    assign frame_done = (state_q == STOP) && bit_end;
    // Old byte is free if unread flag is low or being acknowledged now
    assign accept     = frame_done && (!ready_q || rx_ack_i);

    // ====================
    // Bit sampling FSM
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            idx_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (!rx_bit) begin
                        state_q <= START;
                    end
                end
                START: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == HALF_LAST) begin
                        // Glitch rejection at mid start bit
                        cnt_q   <= '0;
                        idx_q   <= '0;
                        state_q <= rx_bit ? IDLE : DATA;
                    end
                end
                DATA: begin
                    cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
                    if (bit_end) begin
                        if (idx_q == IDX_LAST) begin
                            state_q <= STOP;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                STOP: begin
                    cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
                    if (bit_end) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DATA && bit_end) begin
            shift_q <= {rx_bit, shift_q[DATA_WIDTH-1:1]};
        end
        if (accept) begin
            data_q <= shift_q;
        end
    end

    // ====================
    // Ready and error flags
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q     <= 1'b0;
            frame_err_q <= 1'b0;
            overrun_q   <= 1'b0;
        end else begin
            if (rx_ack_i) begin
                ready_q <= 1'b0;
            end
            if (clr_frame_i) begin
                frame_err_q <= 1'b0;
            end
            if (clr_overrun_i) begin
                overrun_q <= 1'b0;
            end
            // New events win over a clear in the same cycle
            if (accept) begin
                ready_q <= 1'b1;
                if (!rx_bit) begin
                    frame_err_q <= 1'b1;
                end
            end else if (frame_done) begin
                overrun_q <= 1'b1;
            end
        end
    end

    assign rx_data_o            = data_q;
    assign rx_ready_o           = ready_q;
    assign rx_flags_o.frame_err = frame_err_q;
    assign rx_flags_o.overrun   = overrun_q;

endmodule

`default_nettype wire

//--- hw/uart_soc_pkg.sv
`default_nettype none

package uart_soc_pkg;

    // ====================
    // Fixed UART geometry
    // ====================
    localparam int DATA_WIDTH   = 8;
    // Short bit period keeps simulation fast
    localparam int CLKS_PER_BIT = 8;

    localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_IDX_W  = $clog2(DATA_WIDTH);

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;
    typedef logic [BIT_IDX_W-1:0]  bit_idx_t;

    // Bit period boundaries shared by both serial engines
    localparam baud_cnt_t BIT_LAST  = baud_cnt_t'(CLKS_PER_BIT - 1);
    localparam baud_cnt_t HALF_LAST = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);
    localparam bit_idx_t  IDX_LAST  = bit_idx_t'(DATA_WIDTH - 1);

    // ====================
    // Register map
    // ====================
    typedef enum logic [1:0] {
        UART_REG_CONTROL = 2'd0,
        UART_REG_STATUS  = 2'd1,
        UART_REG_DATA    = 2'd2
    } uart_reg_offset_e;

    // Status register bits
    localparam int STAT_TX_EMPTY_BIT  = 0;
    localparam int STAT_RX_READY_BIT  = 1;
    localparam int STAT_FRAME_ERR_BIT = 2;
    localparam int STAT_OVERRUN_BIT   = 3;

    // Control register bits, both self-clearing
    localparam int CTRL_CLR_FRAME_BIT   = 0;
    localparam int CTRL_CLR_OVERRUN_BIT = 1;

    // One register access as seen by host ports and the register block
    typedef struct packed {
        uart_reg_offset_e offset;
        logic             write;
        data_t            wdata;
    } bus_req_t;

    typedef struct packed {
        logic frame_err;
        logic overrun;
    } rx_flags_t;

endpackage

`default_nettype wire

//--- hw/uart_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module uart_subsystem (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   req_a_i,
    input  wire uart_soc_pkg::bus_req_t cmd_a_i,
    output logic                        ack_a_o,
    output uart_soc_pkg::data_t         rdata_a_o,
    input  wire logic                   req_b_i,
    input  wire uart_soc_pkg::bus_req_t cmd_b_i,
    output logic                        ack_b_o,
    output uart_soc_pkg::data_t         rdata_b_o,
    input  wire logic                   serial_rx_i,
    output logic                        serial_tx_o
);

    import uart_soc_pkg::*;

    // Shared register bus
    logic      bus_valid;
    bus_req_t  bus_cmd;
    data_t     bus_rdata;

    // Register block to serial engines
    data_t     tx_data;
    logic      tx_start;
    logic      tx_busy;
    data_t     rx_data;
    logic      rx_ready;
    rx_flags_t rx_flags;
    logic      rx_ack;
    logic      clr_frame;
    logic      clr_overrun;

    bus_arbiter u_arbiter (
        .clk         (clk),
        .reset       (reset),
        .req_a_i     (req_a_i),
        .req_b_i     (req_b_i),
        .cmd_a_i     (cmd_a_i),
        .cmd_b_i     (cmd_b_i),
        .ack_a_o     (ack_a_o),
        .ack_b_o     (ack_b_o),
        .rdata_a_o   (rdata_a_o),
        .rdata_b_o   (rdata_b_o),
        .bus_valid_o (bus_valid),
        .bus_cmd_o   (bus_cmd),
        .bus_rdata_i (bus_rdata)
    );

    uart_regs u_regs (
        .clk           (clk),
        .reset         (reset),
        .bus_valid_i   (bus_valid),
        .bus_cmd_i     (bus_cmd),
        .bus_rdata_o   (bus_rdata),
        .tx_data_o     (tx_data),
        .tx_start_o    (tx_start),
        .tx_busy_i     (tx_busy),
        .rx_data_i     (rx_data),
        .rx_ready_i    (rx_ready),
        .rx_flags_i    (rx_flags),
        .rx_ack_o      (rx_ack),
        .clr_frame_o   (clr_frame),
        .clr_overrun_o (clr_overrun)
    );

    uart_tx u_tx (
        .clk         (clk),
        .reset       (reset),
        .tx_data_i   (tx_data),
        .tx_start_i  (tx_start),
        .tx_busy_o   (tx_busy),
        .serial_tx_o (serial_tx_o)
    );

    uart_rx u_rx (
        .clk           (clk),
        .reset         (reset),
        .serial_rx_i   (serial_rx_i),
        .rx_ack_i      (rx_ack),
        .clr_frame_i   (clr_frame),
        .clr_overrun_i (clr_overrun),
        .rx_data_o     (rx_data),
        .rx_ready_o    (rx_ready),
        .rx_flags_o    (rx_flags)
    );

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire uart_soc_pkg::data_t tx_data_i,
    input  wire logic                tx_start_i,
    output logic                     tx_busy_o,
    output logic                     serial_tx_o
);

    import uart_soc_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } tx_state_e;

    tx_state_e state_q;
    baud_cnt_t cnt_q;
    bit_idx_t  idx_q;
    data_t     shift_q;
    logic      bit_end;

    assign bit_end = (cnt_q == BIT_LAST);

    // ====================
    // Frame sequencing
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            idx_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (tx_start_i) begin
                        state_q <= START;
                    end
                end
                START: begin
                    cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
                    if (bit_end) begin
                        idx_q   <= '0;
                        state_q <= DATA;
                    end
                end
                DATA: begin
                    cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
                    if (bit_end) begin
                        if (idx_q == IDX_LAST) begin
                            state_q <= STOP;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                STOP: begin
                    cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
                    if (bit_end) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // LSB goes out first
    always_ff @(posedge clk) begin
        if (state_q == IDLE && tx_start_i) begin
            shift_q <= tx_data_i;
        end else if (state_q == DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_comb begin
        case (state_q)
            START:   serial_tx_o = 1'b0;
            DATA:    serial_tx_o = shift_q[0];
            default: serial_tx_o = 1'b1;
        endcase
    end

    assign tx_busy_o = (state_q != IDLE);

endmodule

`default_nettype wire

//--- verification/tb_uart_tasks.svh
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// ====================
// Reference model
// ====================
data_t exp_ctrl      = '0;
data_t exp_rx_byte   = '0;
logic  exp_rx_ready  = 1'b0;
logic  exp_frame_err = 1'b0;
logic  exp_overrun   = 1'b0;

// Clear bits self-clear, so a later read shows them as zero
task automatic model_ctrl_write(input data_t value);
    exp_ctrl = value;
    exp_ctrl[CTRL_CLR_FRAME_BIT]   = 1'b0;
    exp_ctrl[CTRL_CLR_OVERRUN_BIT] = 1'b0;
    if (value[CTRL_CLR_FRAME_BIT]) begin
        exp_frame_err = 1'b0;
    end
    if (value[CTRL_CLR_OVERRUN_BIT]) begin
        exp_overrun = 1'b0;
    end
endtask

// Unread byte is kept, a new one only raises overrun
task automatic model_byte_in(input data_t value, input logic stop_bit);
    if (exp_rx_ready) begin
        exp_overrun = 1'b1;
    end else begin
        exp_rx_byte  = value;
        exp_rx_ready = 1'b1;
        if (!stop_bit) begin
            exp_frame_err = 1'b1;
        end
    end
endtask

function automatic data_t status_word(input logic tx_empty);
    data_t word;
    word = '0;
    word[STAT_TX_EMPTY_BIT]  = tx_empty;
    word[STAT_RX_READY_BIT]  = exp_rx_ready;
    word[STAT_FRAME_ERR_BIT] = exp_frame_err;
    word[STAT_OVERRUN_BIT]   = exp_overrun;
    return word;
endfunction

task automatic report_mismatch(input string name, input int expected, input int actual);
    $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
    err_cnt++;
endtask

// ====================
// Host port transactions
// ====================
task automatic bus_xfer(input logic port_b, input bus_req_t cmd, output data_t rdata);
    int   waited;
    logic ack;
    waited = 0;
    ack    = 1'b0;
    @(negedge clk);
    if (port_b) begin
        cmd_b = cmd;
        req_b = 1'b1;
        req_cnt_b++;
    end else begin
        cmd_a = cmd;
        req_a = 1'b1;
        req_cnt_a++;
    end
    while (!ack && waited < ACK_LIMIT) begin
        @(negedge clk);
        waited++;
        ack = port_b ? ack_b : ack_a;
    end
    if (!ack) begin
        $display("Port %s got no ack within %0d cycles", port_b ? "B" : "A", ACK_LIMIT);
        err_cnt++;
    end
    rdata = port_b ? rdata_b : rdata_a;
    if (port_b) begin
        req_b = 1'b0;
    end else begin
        req_a = 1'b0;
    end
    // Return to zero before the next request
    while (ack && waited < 2 * ACK_LIMIT) begin
        @(negedge clk);
        waited++;
        ack = port_b ? ack_b : ack_a;
    end
    if (ack) begin
        $display("Port %s ack stayed high after req fell", port_b ? "B" : "A");
        err_cnt++;
    end
endtask

task automatic reg_write(input logic port_b, input uart_reg_offset_e offset, input data_t value);
    bus_req_t cmd;
    data_t    unused;
    cmd.offset = offset;
    cmd.write  = 1'b1;
    cmd.wdata  = value;
    bus_xfer(port_b, cmd, unused);
endtask

task automatic reg_read(input logic port_b, input uart_reg_offset_e offset, output data_t value);
    bus_req_t cmd;
    cmd.offset = offset;
    cmd.write  = 1'b0;
    cmd.wdata  = '0;
    bus_xfer(port_b, cmd, value);
endtask

task automatic wait_status(input logic port_b, input int bit_pos, input logic value,
                           output data_t status);
    int tries;
    tries = 0;
    reg_read(port_b, UART_REG_STATUS, status);
    while (status[bit_pos] !== value && tries < POLL_LIMIT) begin
        reg_read(port_b, UART_REG_STATUS, status);
        tries++;
    end
    if (status[bit_pos] !== value) begin
        $display("STATUS bit %0d did not reach %0b after %0d reads", bit_pos, value, POLL_LIMIT);
        err_cnt++;
    end
endtask

// ====================
// Serial frame driver
// ====================
task automatic send_frame(input data_t value, input logic stop_bit);
    logic [DATA_WIDTH+1:0] bits;
    bits = {stop_bit, value, 1'b0};
    for (int i = 0; i < DATA_WIDTH + 2; i++) begin
        @(negedge clk);
        drv_line = bits[i];
        repeat (CLKS_PER_BIT - 1) @(negedge clk);
    end
    @(negedge clk);
    drv_line = 1'b1;
endtask

`endif

//--- verification/tb_uart_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_uart_subsystem;

    import uart_soc_pkg::*;

    localparam int FRAME_CYCLES    = (DATA_WIDTH + 2) * CLKS_PER_BIT;
    localparam int WATCHDOG_CYCLES = 20 * FRAME_CYCLES + 2000;
    localparam int ACK_LIMIT       = 64;
    localparam int POLL_LIMIT      = 50;
    localparam int CTRL_ROUNDS     = 16;
    localparam int LOOP_BYTES      = 8;
    localparam int ARB_ROUNDS      = 40;
    localparam logic [31:0] SEED   = 32'h2455;

    logic     clk;
    logic     reset;
    logic     req_a;
    bus_req_t cmd_a;
    logic     ack_a;
    data_t    rdata_a;
    logic     req_b;
    bus_req_t cmd_b;
    logic     ack_b;
    data_t    rdata_b;
    logic     serial_rx;
    logic     serial_tx;
    logic     loopback;
    logic     drv_line;

    int   err_cnt    = 0;
    int   req_cnt_a  = 0;
    int   req_cnt_b  = 0;
    int   ack_rise_a = 0;
    int   ack_rise_b = 0;
    logic ack_a_prev = 1'b0;
    logic ack_b_prev = 1'b0;

    `include "tb_uart_tasks.svh"

    uart_subsystem uart_subsystem_i (
        .clk         (clk),
        .reset       (reset),
        .req_a_i     (req_a),
        .cmd_a_i     (cmd_a),
        .ack_a_o     (ack_a),
        .rdata_a_o   (rdata_a),
        .req_b_i     (req_b),
        .cmd_b_i     (cmd_b),
        .ack_b_o     (ack_b),
        .rdata_b_o   (rdata_b),
        .serial_rx_i (serial_rx),
        .serial_tx_o (serial_tx)
    );

    // Loopback or testbench frame driver
    assign serial_rx = loopback ? serial_tx : drv_line;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // Ack overlap and ack counting
    always @(negedge clk) begin
        if (!reset && ack_a && ack_b) begin
            $display("Both host acks high at %0t", $time);
            err_cnt++;
        end
        if (ack_a && !ack_a_prev) begin
            ack_rise_a++;
        end
        if (ack_b && !ack_b_prev) begin
            ack_rise_b++;
        end
        ack_a_prev = ack_a;
        ack_b_prev = ack_b;
    end

    // Op 0 reads STATUS, op 1 reads CONTROL, op 2 writes CONTROL
    task automatic run_op(input logic port_b, input int unsigned op, input data_t value,
                          output data_t rdata);
        rdata = '0;
        case (op)
            0:       reg_read(port_b, UART_REG_STATUS, rdata);
            1:       reg_read(port_b, UART_REG_CONTROL, rdata);
            default: reg_write(port_b, UART_REG_CONTROL, value);
        endcase
    endtask

    function automatic data_t expected_read(input int unsigned op);
        return (op == 0) ? status_word(1'b1) : exp_ctrl;
    endfunction

    initial begin
        data_t       rd;
        data_t       rd_b;
        data_t       value;
        data_t       value_b;
        logic        port;
        int unsigned op_a;
        int unsigned op_b;
        void'($urandom(SEED));
        reset    = 1'b1;
        req_a    = 1'b0;
        req_b    = 1'b0;
        cmd_a    = '0;
        cmd_b    = '0;
        drv_line = 1'b1;
        loopback = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // ====================
        // Control readback
        // ====================
        for (int i = 0; i < CTRL_ROUNDS; i++) begin
            value = data_t'($urandom);
            port  = 1'($urandom);
            reg_write(port, UART_REG_CONTROL, value);
            model_ctrl_write(value);
            port = 1'($urandom);
            reg_read(port, UART_REG_CONTROL, rd);
            if (rd !== exp_ctrl) report_mismatch("ctrl_readback", exp_ctrl, rd);
        end

        // ====================
        // Serial loopback
        // ====================
        loopback = 1'b1;
        for (int i = 0; i < LOOP_BYTES; i++) begin
            value = data_t'($urandom);
            port  = 1'($urandom);
            wait_status(port, STAT_TX_EMPTY_BIT, 1'b1, rd);
            reg_write(port, UART_REG_DATA, value);
            wait_status(port, STAT_RX_READY_BIT, 1'b1, rd);
            model_byte_in(value, 1'b1);
            reg_read(port, UART_REG_DATA, rd);
            if (rd !== exp_rx_byte) report_mismatch("loopback_data", exp_rx_byte, rd);
            exp_rx_ready = 1'b0;
            reg_read(port, UART_REG_STATUS, rd);
            if (rd[STAT_RX_READY_BIT] !== exp_rx_ready) begin
                report_mismatch("loopback_ready", exp_rx_ready, rd[STAT_RX_READY_BIT]);
            end
        end
        loopback = 1'b0;

        // Frame error on a zero stop bit
        value = data_t'($urandom);
        send_frame(value, 1'b0);
        model_byte_in(value, 1'b0);
        wait_status(1'b0, STAT_RX_READY_BIT, 1'b1, rd);
        if (rd !== status_word(1'b1)) report_mismatch("frame_status", status_word(1'b1), rd);
        reg_read(1'b1, UART_REG_DATA, rd);
        if (rd !== exp_rx_byte) report_mismatch("frame_data", exp_rx_byte, rd);
        exp_rx_ready = 1'b0;
        reg_write(1'b0, UART_REG_CONTROL, data_t'(1 << CTRL_CLR_FRAME_BIT));
        model_ctrl_write(data_t'(1 << CTRL_CLR_FRAME_BIT));
        reg_read(1'b1, UART_REG_STATUS, rd);
        if (rd !== status_word(1'b1)) report_mismatch("frame_clear", status_word(1'b1), rd);

        // Overrun with two unread frames
        value   = data_t'($urandom);
        value_b = data_t'($urandom);
        send_frame(value, 1'b1);
        model_byte_in(value, 1'b1);
        send_frame(value_b, 1'b1);
        model_byte_in(value_b, 1'b1);
        wait_status(1'b1, STAT_OVERRUN_BIT, 1'b1, rd);
        if (rd !== status_word(1'b1)) report_mismatch("overrun_status", status_word(1'b1), rd);
        reg_read(1'b0, UART_REG_DATA, rd);
        if (rd !== exp_rx_byte) report_mismatch("overrun_data", exp_rx_byte, rd);
        exp_rx_ready = 1'b0;
        reg_write(1'b1, UART_REG_CONTROL, data_t'(1 << CTRL_CLR_OVERRUN_BIT));
        model_ctrl_write(data_t'(1 << CTRL_CLR_OVERRUN_BIT));
        reg_read(1'b0, UART_REG_STATUS, rd);
        if (rd !== status_word(1'b1)) report_mismatch("overrun_clear", status_word(1'b1), rd);

        // ====================
        // Concurrent host traffic
        // ====================
        for (int i = 0; i < ARB_ROUNDS; i++) begin
            op_a    = $urandom % 3;
            op_b    = $urandom % 3;
            value   = data_t'($urandom);
            value_b = data_t'($urandom);
            // Keep CONTROL reads free of a racing write
            if (op_a == 2 && op_b != 0) begin
                op_b = 0;
            end else if (op_b == 2 && op_a == 1) begin
                op_a = 0;
            end
            fork
                run_op(1'b0, op_a, value, rd);
                run_op(1'b1, op_b, value_b, rd_b);
            join
            if (op_a != 2 && rd !== expected_read(op_a)) begin
                report_mismatch("arb_port_a", expected_read(op_a), rd);
            end
            if (op_b != 2 && rd_b !== expected_read(op_b)) begin
                report_mismatch("arb_port_b", expected_read(op_b), rd_b);
            end
            if (op_a == 2) model_ctrl_write(value);
            if (op_b == 2) model_ctrl_write(value_b);
        end
        if (ack_rise_a != req_cnt_a) report_mismatch("ack_count_a", req_cnt_a, ack_rise_a);
        if (ack_rise_b != req_cnt_b) report_mismatch("ack_count_b", req_cnt_b, ack_rise_b);

        $display("Errors: %0d, transactions A: %0d, B: %0d", err_cnt, req_cnt_a, req_cnt_b);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verification
hw/uart_soc_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_regs.sv
hw/bus_arbiter.sv
hw/uart_subsystem.sv
verification/tb_uart_subsystem.sv
